// ==== list.f ====
logic/leaf_in_pkg.sv
logic/packet_decode.sv
logic/reorder_buffer.sv
logic/payload_fifo.sv
logic/width_converter.sv
logic/port_counters.sv
logic/leaf_input_port.sv
tb/leaf_input_port_sva.sv
tb/tb_leaf_input_port.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the leaf input port testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_leaf_input_port

verilator --binary --timing --assert -f list.f --top-module "$TOP" -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation finished without failure"
exit 0

// ==== tb/tb_leaf_input_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_leaf_input_port;
    import leaf_in_pkg::*;

    localparam int          CLK_PERIOD  = 100;
    localparam int          RESET_CYC   = 5;
    localparam int          PORT_NO     = 2;
    localparam int          FIFO_DEPTH  = 16;
    localparam logic [5:0]  SRC_LEAF    = 6'h2d;
    localparam logic [3:0]  SRC_PORT    = 4'h2;
    localparam int          DRAIN_LIMIT = 200;   // cycles allowed per drain
    // reset + in-order + filter + back-pressure + credit + counters
    localparam int          TEST_CYC    = RESET_CYC + 40 + 20 + 100 + 100 + 80;

    logic                    clk_user;
    logic                    reset_user;
    logic [PACKET_BITS-1:0]  packet_in;
    logic                    ack_user;
    logic                    done_mode;
    logic [USER_BITS-1:0]    dout2user;
    logic                    vld2user;
    logic                    freespace_update;
    logic [PACKET_BITS-1:0]  update_packet;
    logic [PAYLOAD_BITS-1:0] full_cnt;
    logic [PAYLOAD_BITS-1:0] empty_cnt;
    logic [PAYLOAD_BITS-1:0] read_cnt;
    logic                    stall;

    // scoreboard state
    logic [USER_BITS-1:0]    exp_q[$];        // user words still owed
    logic [PAYLOAD_BITS-1:0] pend_data [128]; // model of the reorder store
    bit                      pend_vld [128];
    logic [ADDR_BITS-1:0]    next_addr;       // next address due out mod 128
    logic [ADDR_BITS-1:0]    tx_addr;         // next address the tests send
    int                      xfers;           // words seen on the user side
    int                      pulses;          // credit pulses seen
    logic [PACKET_BITS-1:0]  credit_pkt;
    logic                    ack_want;
    logic                    done_want;
    integer                  seed;

    leaf_input_port #(
        .PORT_NO(PORT_NO), .FREESPACE_UPDATE_SIZE(64), .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .clk_user, .reset_user, .packet_in, .src_leaf(SRC_LEAF), .src_port(SRC_PORT),
        .ack_user, .done_mode, .dout2user, .vld2user, .freespace_update, .update_packet,
        .full_cnt, .empty_cnt, .read_cnt, .stall
    );

    bind leaf_input_port leaf_input_port_sva u_sva (
        .clk_user(clk_user), .reset_user(reset_user), .vld2user(vld2user),
        .ack_user(ack_user), .dout2user(dout2user), .freespace_update(freespace_update)
    );

    initial begin
        clk_user = 1'b0;
        forever #(CLK_PERIOD / 2) clk_user = ~clk_user;
    end

    //////////////////////////////
    // reporting and stimulus
    //////////////////////////////
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else stop_with_failure($sformatf(
            "CHECK FAILED time=%0t signal=%s got=%h exp=%h", $time, name, got, exp));
    endtask

    // bit 96 valid, 95:90 leaf, 89:86 port, 85:71 zero, 70:64 addr
    function automatic logic [PACKET_BITS-1:0] build_packet(
        input logic vld, input logic [5:0] leaf, input logic [3:0] port,
        input logic [6:0] addr, input logic [63:0] data);
        logic [PACKET_BITS-1:0] p;
        p         = '0;
        p[96]     = vld;
        p[95:90]  = leaf;
        p[89:86]  = port;
        p[70:64]  = addr;
        p[63:0]   = data;
        return p;
    endfunction

    // outputs sampled before the new drive, so they belong to the last edge
    task automatic step_cycle(input logic [PACKET_BITS-1:0] pkt);
        @(negedge clk_user);
        if (freespace_update) begin
            pulses++;
            credit_pkt = update_packet;
        end
        packet_in = pkt;
        ack_user  = ack_want;
        done_mode = done_want;
        if (vld2user && ack_user) begin   // word moves on the coming edge
            if (exp_q.size() == 0) begin
                stop_with_failure("a user word came out with no payload outstanding");
            end
            check_value("dout2user", 128'(dout2user), 128'(exp_q.pop_front()));
            xfers++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step_cycle('0);
    endtask

    // in-order release model with the low half first
    task automatic model_accept(input logic [6:0] addr, input logic [63:0] data);
        pend_data[addr] = data;
        pend_vld[addr]  = 1'b1;
        while (pend_vld[next_addr]) begin
            exp_q.push_back(pend_data[next_addr][31:0]);
            exp_q.push_back(pend_data[next_addr][63:32]);
            pend_vld[next_addr] = 1'b0;
            next_addr           = next_addr + 7'd1;
        end
    endtask

    task automatic send_packet(input logic [6:0] addr, input logic [63:0] data,
                               input logic vld, input logic [3:0] port);
        step_cycle(build_packet(vld, SRC_LEAF, port, addr, data));
        if (vld && port == 4'(PORT_NO)) model_accept(addr, data);
    endtask

    task automatic drain_words();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            step_cycle('0);
            n++;
            if (n > DRAIN_LIMIT) stop_with_failure("user words did not arrive in time");
        end
        idle_cycles(3);
        check_value("vld2user", 128'(vld2user), 128'(1'b0));   // nothing extra
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_in_order();
        int order[8] = '{3, 0, 6, 1, 7, 2, 5, 4};
        logic [63:0] start_rd;
        start_rd = read_cnt;
        foreach (order[i]) begin
            send_packet(7'(order[i]), {$random(seed), $random(seed)}, 1'b1, 4'(PORT_NO));
        end
        drain_words();
        check_value("read_cnt", 128'(read_cnt - start_rd), 128'(16));
        tx_addr = 7'd8;
    endtask

    task automatic test_filter();
        send_packet(tx_addr, {$random(seed), $random(seed)}, 1'b0, 4'(PORT_NO)); // valid low
        send_packet(tx_addr, {$random(seed), $random(seed)}, 1'b1, 4'(PORT_NO + 1));
        idle_cycles(6);
        check_value("vld2user", 128'(vld2user), 128'(1'b0));
        send_packet(tx_addr, {$random(seed), $random(seed)}, 1'b1, 4'(PORT_NO));
        drain_words();
        tx_addr = tx_addr + 7'd1;
    endtask

    task automatic test_back_pressure();
        logic [63:0] start_rd;
        start_rd = read_cnt;
        ack_want = 1'b0;
        repeat (24) begin
            send_packet(tx_addr, {$random(seed), $random(seed)}, 1'b1, 4'(PORT_NO));
            tx_addr = tx_addr + 7'd1;
        end
        idle_cycles(4);
        assert (full_cnt != 0) else stop_with_failure($sformatf(
            "CHECK FAILED time=%0t signal=full_cnt got=%0d exp=nonzero", $time, full_cnt));
        ack_want = 1'b1;
        drain_words();
        check_value("read_cnt", 128'(read_cnt - start_rd), 128'(48));
    endtask

    task automatic test_credit();
        check_value("credit pulses", 128'(pulses), 128'(0));   // 33 released so far
        repeat (31) begin
            send_packet(tx_addr, {$random(seed), $random(seed)}, 1'b1, 4'(PORT_NO));
            tx_addr = tx_addr + 7'd1;
        end
        drain_words();
        check_value("credit pulses", 128'(pulses), 128'(1));
        check_value("update_packet", 128'(credit_pkt),
                    128'(build_packet(1'b1, SRC_LEAF, SRC_PORT, 7'd0, 64'd1)));
    endtask

    task automatic test_counters();
        logic [63:0] snap_full;
        logic [63:0] snap_empty;
        logic [63:0] snap_read;
        check_value("stall", 128'(stall), 128'(1'b1));        // idle, ack high
        check_value("read_cnt", 128'(read_cnt), 128'(xfers));
        done_want = 1'b1;
        idle_cycles(2);
        snap_full  = full_cnt;
        snap_empty = empty_cnt;
        snap_read  = read_cnt;
        ack_want   = 1'b0;   // fifo backs up while frozen
        repeat (FIFO_DEPTH + 1) begin
            send_packet(tx_addr, {$random(seed), $random(seed)}, 1'b1, 4'(PORT_NO));
            tx_addr = tx_addr + 7'd1;
        end
        idle_cycles(4);
        ack_want = 1'b1;
        drain_words();
        check_value("full_cnt", 128'(full_cnt), 128'(snap_full));
        check_value("empty_cnt", 128'(empty_cnt), 128'(snap_empty));
        check_value("read_cnt", 128'(read_cnt), 128'(snap_read));
        check_value("stall", 128'(stall), 128'(1'b0));
        check_value("credit pulses", 128'(pulses), 128'(1));  // 81 released, no new credit
        done_want = 1'b0;
    endtask

    // watchdog at twice the test budget
    initial begin
        repeat (TEST_CYC * 2) @(posedge clk_user);
        stop_with_failure("watchdog expired before the tests finished");
    end

    initial begin
        seed       = 32'hb90f;
        reset_user = 1'b1;
        packet_in  = '0;
        ack_user   = 1'b1;
        done_mode  = 1'b0;
        ack_want   = 1'b1;
        done_want  = 1'b0;
        next_addr  = '0;
        tx_addr    = '0;
        xfers      = 0;
        pulses     = 0;
        credit_pkt = '0;
        foreach (pend_vld[i]) pend_vld[i] = 1'b0;
        repeat (RESET_CYC) @(negedge clk_user);
        reset_user = 1'b0;
        test_in_order();
        test_filter();
        test_back_pressure();
        test_credit();
        test_counters();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/leaf_input_port_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module leaf_input_port_sva (
    input wire                                clk_user,
    input wire                                reset_user,
    input wire                                vld2user,
    input wire                                ack_user,
    input wire [leaf_in_pkg::USER_BITS-1:0]   dout2user,
    input wire                                freespace_update
);

    // offered word waits for ack without moving
    a_hold_until_ack: assert property (@(posedge clk_user) disable iff (reset_user)
        vld2user && !ack_user |=> vld2user && $stable(dout2user))
        else $error("user word changed before ack");

    // credit is a single cycle strobe
    a_credit_one_cycle: assert property (@(posedge clk_user) disable iff (reset_user)
        freespace_update |=> !freespace_update)
        else $error("freespace_update held longer than one cycle");

    // no word offered straight out of reset
    a_quiet_after_reset: assert property (@(posedge clk_user)
        reset_user |=> !vld2user)
        else $error("vld2user high in the cycle after reset");

endmodule

`default_nettype wire

// ==== logic/leaf_input_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module leaf_input_port #(
    parameter int PORT_NO               = 2,
    parameter int FREESPACE_UPDATE_SIZE = 64,
    parameter int FIFO_DEPTH            = 16
) (
    input  wire                                  clk_user,
    input  wire                                  reset_user,
    input  wire  [leaf_in_pkg::PACKET_BITS-1:0]  packet_in,
    input  wire  [leaf_in_pkg::LEAF_BITS-1:0]    src_leaf,
    input  wire  [leaf_in_pkg::PORT_BITS-1:0]    src_port,
    input  wire                                  ack_user,
    input  wire                                  done_mode,
    output logic [leaf_in_pkg::USER_BITS-1:0]    dout2user,
    output logic                                 vld2user,
    output logic                                 freespace_update,
    output logic [leaf_in_pkg::PACKET_BITS-1:0]  update_packet,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] full_cnt,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] empty_cnt,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] read_cnt,
    output logic                                 stall
);
    import leaf_in_pkg::*;

    // decode -> buffer
    logic                    wr_en;
    logic [ADDR_BITS-1:0]    wr_addr;
    logic [PAYLOAD_BITS-1:0] wr_payload;
    // buffer -> fifo
    logic                    push;
    logic [PAYLOAD_BITS-1:0] push_data;
    logic                    full;
    // fifo -> converter
    logic                    pop;
    logic [PAYLOAD_BITS-1:0] pop_data;
    logic                    empty;

    packet_decode #(.PORT_NO(PORT_NO)) u_decode (
        .clk_user, .reset_user, .packet_in, .wr_en, .wr_addr, .wr_payload
    );

    reorder_buffer #(.FREESPACE_UPDATE_SIZE(FREESPACE_UPDATE_SIZE)) u_rob (
        .clk_user, .reset_user, .wr_en, .wr_addr, .wr_payload, .full,
        .src_leaf, .src_port, .push, .push_data, .freespace_update, .update_packet
    );

    payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_user, .reset_user, .push, .push_data, .pop, .pop_data, .full, .empty
    );

    width_converter u_conv (
        .clk_user, .reset_user, .pop_data, .empty, .ack_user, .pop, .dout2user, .vld2user
    );

    // perf counters watch the fifo flags and the user handshake
    port_counters u_cnt (
        .clk_user, .reset_user, .done_mode, .full, .empty, .vld2user, .ack_user,
        .full_cnt, .empty_cnt, .read_cnt, .stall
    );

endmodule

`default_nettype wire

// ==== logic/port_counters.sv ====
`timescale 1ns/100ps
`default_nettype none

module port_counters (
    input  wire                                  clk_user,
    input  wire                                  reset_user,
    input  wire                                  done_mode,
    input  wire                                  full,
    input  wire                                  empty,
    input  wire                                  vld2user,
    input  wire                                  ack_user,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] full_cnt,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] empty_cnt,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] read_cnt,
    output logic                                 stall
);

    // user is ready but there is nothing queued
    assign stall = !done_mode && ack_user && empty;

    // all three freeze once done mode is on
    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            full_cnt  <= '0;
            empty_cnt <= '0;
            read_cnt  <= '0;
        end else if (!done_mode) begin
            if (full)              full_cnt  <= full_cnt + 1'b1;   // fifo backed up
            if (empty)             empty_cnt <= empty_cnt + 1'b1;  // fifo starved
            if (vld2user && ack_user) begin
                read_cnt <= read_cnt + 1'b1;  // one user word
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/width_converter.sv ====
`timescale 1ns/100ps
`default_nettype none

module width_converter (
    input  wire                                  clk_user,
    input  wire                                  reset_user,
    input  wire  [leaf_in_pkg::PAYLOAD_BITS-1:0] pop_data,
    input  wire                                  empty,
    input  wire                                  ack_user,
    output logic                                 pop,
    output logic [leaf_in_pkg::USER_BITS-1:0]    dout2user,
    output logic                                 vld2user
);
    import leaf_in_pkg::*;

    half_sel_e state;
    logic      xfer;   // word taken by the user this cycle

    // fifo head is the word source, nothing moves until a transfer
    assign vld2user = !empty;
    assign xfer     = vld2user && ack_user;

    ////////////////////////////////
    // half select
    ////////////////////////////////
    always_comb begin
        case (state)
            HALF_HIGH: dout2user = pop_data[PAYLOAD_BITS-1:USER_BITS];
            default:   dout2user = pop_data[USER_BITS-1:0];   // low half first
        endcase
    end

    // head leaves the fifo only once its high half is taken
    assign pop = xfer && (state == HALF_HIGH);

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            state <= HALF_LOW;
        end else if (xfer) begin
            case (state)
                HALF_LOW:  state <= HALF_HIGH;
                HALF_HIGH: state <= HALF_LOW;   // next payload starts low
                default:   state <= HALF_LOW;
            endcase
        end
    end

    // ack low just holds everything in place

endmodule

`default_nettype wire

// ==== logic/payload_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module payload_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                                  clk_user,
    input  wire                                  reset_user,
    input  wire                                  push,
    input  wire  [leaf_in_pkg::PAYLOAD_BITS-1:0] push_data,
    input  wire                                  pop,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] pop_data,
    output logic                                 full,
    output logic                                 empty
);
    import leaf_in_pkg::*;

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]     wr_ptr;
    logic [PTR_BITS-1:0]     rd_ptr;
    logic [CNT_BITS-1:0]     count;    // occupancy
    logic                    do_push;
    logic                    do_pop;

    // wrap for any depth, not just powers of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
        if (p == PTR_BITS'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full     = (count == CNT_BITS'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;   // guard against overrun
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];     // head shown without a pop, fwft

    always_ff @(posedge clk_user) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int FREESPACE_UPDATE_SIZE = 64
) (
    input  wire                                  clk_user,
    input  wire                                  reset_user,
    input  wire                                  wr_en,
    input  wire  [leaf_in_pkg::ADDR_BITS-1:0]    wr_addr,
    input  wire  [leaf_in_pkg::PAYLOAD_BITS-1:0] wr_payload,
    input  wire                                  full,
    input  wire  [leaf_in_pkg::LEAF_BITS-1:0]    src_leaf,
    input  wire  [leaf_in_pkg::PORT_BITS-1:0]    src_port,
    output logic                                 push,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] push_data,
    output logic                                 freespace_update,
    output logic [leaf_in_pkg::PACKET_BITS-1:0]  update_packet
);
    import leaf_in_pkg::*;

    localparam int DEPTH    = 2 ** ADDR_BITS;   // one slot per sequence address
    localparam int CNT_BITS = (FREESPACE_UPDATE_SIZE > 1) ? $clog2(FREESPACE_UPDATE_SIZE) : 1;

    logic [PAYLOAD_BITS-1:0] mem [DEPTH];
    logic [DEPTH-1:0]        filled;   // slot holds an unreleased payload
    logic [ADDR_BITS-1:0]    rd_ptr;   // next address to go out
    logic [CNT_BITS-1:0]     rel_cnt;  // releases since last credit

    // head goes out the first cycle it's present and the fifo has room
    assign push      = filled[rd_ptr] && !full;
    assign push_data = mem[rd_ptr];

    ////////////////////////////////
    // payload store
    ////////////////////////////////
    always_ff @(posedge clk_user) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_payload;
        end
    end

    // flags and read pointer
    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            filled <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                filled[rd_ptr] <= 1'b0;         // slot freed on release
                rd_ptr         <= rd_ptr + 1'b1; // natural wrap at 128
            end
            // sender credits keep a write off the slot being released
            if (wr_en) begin
                filled[wr_addr] <= 1'b1;
            end
        end
    end

    ////////////////////////////////
    // credit back to the network
    ////////////////////////////////
    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            rel_cnt          <= '0;
            freespace_update <= 1'b0;
        end else begin
            freespace_update <= 1'b0;  // single cycle pulse
            if (push) begin
                if (rel_cnt == CNT_BITS'(FREESPACE_UPDATE_SIZE - 1)) begin
                    rel_cnt          <= '0;
                    freespace_update <= 1'b1;
                end else begin
                    rel_cnt <= rel_cnt + 1'b1;
                end
            end
        end
    end

    // credit word, payload of 1 and address left at zero
    always_comb begin
        update_packet                    = '0;
        update_packet[VLD_POS]           = freespace_update;
        update_packet[LEAF_HI:LEAF_LO]   = src_leaf;
        update_packet[PORT_HI:PORT_LO]   = src_port;
        update_packet[PAYLOAD_BITS-1:0]  = PAYLOAD_BITS'(1);
    end

endmodule

`default_nettype wire

// ==== logic/packet_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module packet_decode #(
    parameter int PORT_NO = 2
) (
    input  wire                                  clk_user,
    input  wire                                  reset_user,
    input  wire  [leaf_in_pkg::PACKET_BITS-1:0]  packet_in,
    output logic                                 wr_en,
    output logic [leaf_in_pkg::ADDR_BITS-1:0]    wr_addr,
    output logic [leaf_in_pkg::PAYLOAD_BITS-1:0] wr_payload
);
    import leaf_in_pkg::*;

    logic                 vld_bit;
    logic [PORT_BITS-1:0] port_field;
    logic                 accept;

    // field split
    assign vld_bit    = packet_in[VLD_POS];
    assign port_field = packet_in[PORT_HI:PORT_LO];

    // only valid packets aimed at this port, leaf is already routed
    assign accept = vld_bit && (port_field == PORT_BITS'(PORT_NO));

    // write strobe, one cycle behind the network word
    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= accept;
        end
    end

    // write fields, only loaded on a hit
    always_ff @(posedge clk_user) begin
        if (accept) begin
            wr_addr    <= packet_in[ADDR_HI:ADDR_LO];
            wr_payload <= packet_in[PAYLOAD_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/leaf_in_pkg.sv ====
`default_nettype none

package leaf_in_pkg;

    ////////////////////////////////
    // field widths
    ////////////////////////////////
    localparam int PACKET_BITS  = 97;   // one network word
    localparam int LEAF_BITS    = 6;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;    // sequence address, wraps at 128
    localparam int PAYLOAD_BITS = 64;
    localparam int USER_BITS    = 32;   // half a payload

    ////////////////////////////////
    // packet layout, msb down
    ////////////////////////////////
    localparam int VLD_POS = PACKET_BITS - 1;           // valid bit on top
    localparam int LEAF_HI = VLD_POS - 1;
    localparam int LEAF_LO = LEAF_HI - LEAF_BITS + 1;
    localparam int PORT_HI = LEAF_LO - 1;
    localparam int PORT_LO = PORT_HI - PORT_BITS + 1;
    // address sits right on top of the payload
    localparam int ADDR_LO = PAYLOAD_BITS;
    localparam int ADDR_HI = ADDR_LO + ADDR_BITS - 1;
    // bits from PORT_LO-1 down to ADDR_HI+1 carry nothing

    // which half of the head payload the converter shows
    typedef enum logic {
        HALF_LOW  = 1'b0,   // bits 31:0, always first
        HALF_HIGH = 1'b1    // bits 63:32
    } half_sel_e;

endpackage

`default_nettype wire
